// File: logic/rsStatsPkg.sv
//####################################################################
// Register map, report and frame structs and control register layout
// shared by the RS decoder statistics block
//####################################################################
`default_nettype none

package rsStatsPkg;

    // Word addresses, only bits 4:2 are decoded
    localparam logic [4:0] addrControl    = 5'h00;
    localparam logic [4:0] addrStatus     = 5'h04;
    localparam logic [4:0] addrAsmControl = 5'h08;

    // One decoded codeword result as delivered by the decoder core
    typedef struct packed {
        logic       valid;      // Single cycle report strobe
        logic [7:0] errors;     // Symbols corrected in this codeword
        logic       fail;       // Codeword was uncorrectable
    } cwReport_t;

    // What a lane holds between its write and the merger drain
    typedef struct packed {
        logic       full;       // A result is waiting in the lane
        logic [7:0] errors;
        logic       fail;
    } laneResult_t;

    // One merged frame, errors is wide enough for 8 lanes of 255
    typedef struct packed {
        logic        valid;
        logic [10:0] errors;
        logic        fail;
    } frameResult_t;

    // Control register, interleave selects the depth I
    typedef struct packed {
        logic [7:0] fill;       // Virtual fill length in symbols
        logic [3:0] interleave; // Interleaving depth
        logic [2:0] reserved;
        logic       rIndex;     // Selects RS(255,223) or RS(255,239)
    } rsControl_t;

    localparam rsControl_t controlReset = 16'h0010; // Depth 1, no fill

    // One bus access with a plain chip select and byte enables
    typedef struct packed {
        logic        cs;
        logic [4:0]  addr;
        logic [3:0]  wrEn;      // One enable per byte lane
        logic [31:0] wrData;
    } busReq_t;

endpackage

`default_nettype wire

// File: logic/codewordDistributor.sv
//####################################################################
// Codeword distributor, steers reports to their interleave lanes
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module codewordDistributor import rsStatsPkg::*; #(
    parameter int maxDepth = 8
) (
    input  wire logic                         busClk,
    input  wire logic                         rstN,
    input  wire cwReport_t                    report,
    input  wire rsControl_t                   control,
    output cwReport_t                         laneWr [maxDepth],
    output logic [$clog2(maxDepth + 1)-1:0]   frameDepth  // Depth of the frame now filling
);

    localparam int laneIdxW = (maxDepth > 1) ? $clog2(maxDepth) : 1;
    localparam int depthW   = $clog2(maxDepth + 1);

    logic [laneIdxW-1:0] pos;      // Codeword position inside the frame
    logic [depthW-1:0]   depthQ;   // Depth latched at the last frame start
    logic [depthW-1:0]   reqDepth; // Clamped depth requested by control
    logic [depthW-1:0]   curDepth; // Depth that applies to this report
    logic                lastPos;

    // Zero means depth 1 and anything beyond the lane count is clipped
    always_comb begin
        if (control.interleave == 4'd0) begin
            reqDepth = depthW'(1);
        end else if (int'(control.interleave) > maxDepth) begin
            reqDepth = depthW'(maxDepth);
        end else begin
            reqDepth = depthW'(control.interleave);
        end
    end

    assign curDepth   = (pos == '0) ? reqDepth : depthQ; // New depth only at position 0
    assign lastPos    = (int'(pos) + 1) == int'(curDepth);
    assign frameDepth = depthQ;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            pos    <= '0;
            depthQ <= depthW'(1);
        end else if (report.valid) begin
            depthQ <= curDepth;
            pos    <= lastPos ? '0 : pos + 1'b1; // Wrap after the last codeword
        end
    end

    // One registered write port per lane, only the addressed lane sees valid
    for (genvar i = 0; i < maxDepth; i++) begin : gLaneWr
        always_ff @(posedge busClk or negedge rstN) begin
            if (!rstN) begin
                laneWr[i] <= '0;
            end else begin
                laneWr[i].valid  <= report.valid && (int'(pos) == i);
                laneWr[i].errors <= report.errors;
                laneWr[i].fail   <= report.fail;
            end
        end
    end

    // Latched depth must always select at least one lane
    assert property (@(posedge busClk) disable iff (!rstN) depthQ != '0);

endmodule

`default_nettype wire

// File: logic/laneAccumulator.sv
//####################################################################
// Lane accumulator, holds one codeword result for the merger
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module laneAccumulator import rsStatsPkg::*; (
    input  wire logic      busClk,
    input  wire logic      rstN,
    input  wire cwReport_t laneWr,     // Registered report for this lane
    input  wire logic      laneDrain,  // Merger has taken the frame
    output laneResult_t    laneState
);

    // A write beats a drain in the same cycle so the next frame is kept
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            laneState <= '0;
        end else if (laneWr.valid) begin
            laneState.full   <= 1'b1;
            laneState.errors <= laneWr.errors;
            laneState.fail   <= laneWr.fail;
        end else if (laneDrain) begin
            laneState.full <= 1'b0; // Payload stays, only full matters
        end
    end

    // There is no back-pressure, a full lane must be drained before reuse
    assert property (@(posedge busClk) disable iff (!rstN)
        laneWr.valid |-> (!laneState.full || laneDrain));

endmodule

`default_nettype wire

// File: logic/frameMerger.sv
//####################################################################
// Frame merger, sums lane errors and ORs lane failures per frame
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module frameMerger import rsStatsPkg::*; #(
    parameter int maxDepth = 8
) (
    input  wire logic                             busClk,
    input  wire logic                             rstN,
    input  wire laneResult_t                      laneState [maxDepth],
    input  wire cwReport_t                        laneWr [maxDepth],
    input  wire logic [$clog2(maxDepth + 1)-1:0]  frameDepth,
    output frameResult_t                          frame,
    output logic                                  laneDrain
);

    localparam int depthW = $clog2(maxDepth + 1);

    logic [depthW-1:0] depthQ;   // Depth of the frame being completed
    logic              complete; // Lanes 0 to depth-1 all hold a result
    logic [10:0]       errSum;
    logic              failAny;

    // The position 0 write marks a frame start, take its depth there
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            depthQ <= depthW'(1);
        end else if (laneWr[0].valid) begin
            depthQ <= frameDepth;
        end
    end

    always_comb begin
        complete = 1'b1;
        errSum   = '0;
        failAny  = 1'b0;
        for (int i = 0; i < maxDepth; i++) begin
            if (i < int'(depthQ)) begin // Lanes past the depth are ignored
                complete = complete & laneState[i].full;
                errSum   = errSum + 11'(laneState[i].errors);
                failAny  = failAny | laneState[i].fail;
            end
        end
    end

    // Drain in the detect cycle so a new position 0 write lands cleanly
    assign laneDrain = complete;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            frame <= '0;
        end else begin
            frame.valid  <= complete;
            frame.errors <= errSum;
            frame.fail   <= failAny;
        end
    end

    // A frame of depth d carries at most d codewords of 255 errors
    assert property (@(posedge busClk) disable iff (!rstN)
        frame.valid |-> int'(frame.errors) <= int'($past(depthQ)) * 255);

endmodule

`default_nettype wire

// File: logic/rsStatsCounters.sv
//####################################################################
// Saturating fail, frame and error counters with clear on read
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module rsStatsCounters import rsStatsPkg::*; (
    input  wire logic         busClk,
    input  wire logic         rstN,
    input  wire frameResult_t frame,
    input  wire logic         clearStats, // Pulse after a status read
    output logic [7:0]        failCnt,
    output logic [7:0]        frameCnt,
    output logic [15:0]       errCnt
);

    logic [16:0] errNext; // One extra bit to spot the carry out

    assign errNext = {1'b0, errCnt} + 17'(frame.errors);

    //####################################################################
    // Counters, a clear wins over a frame in the same cycle
    //####################################################################

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            failCnt  <= '0;
            frameCnt <= '0;
            errCnt   <= '0;
        end else if (clearStats) begin
            failCnt  <= '0;
            frameCnt <= '0;
            errCnt   <= '0; // A frame arriving now is dropped
        end else if (frame.valid) begin
            if (frameCnt != 8'hFF) begin
                frameCnt <= frameCnt + 1'b1;
            end
            if (frame.fail && (failCnt != 8'hFF)) begin
                failCnt <= failCnt + 1'b1;
            end
            // Clip at the top instead of wrapping
            errCnt <= errNext[16] ? 16'hFFFF : errNext[15:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/rsRegs.sv
//####################################################################
// Register file, byte lane writes, read mux and clear strobe
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module rsRegs import rsStatsPkg::*; (
    input  wire logic        busClk,
    input  wire logic        rstN,
    input  wire busReq_t     bus,
    input  wire logic [7:0]  failCnt,
    input  wire logic [7:0]  frameCnt,
    input  wire logic [15:0] errCnt,
    output logic [31:0]      readData,
    output rsControl_t       control,
    output logic [31:0]      asmControl,
    output logic             clearStats
);

    logic isControl;
    logic isStatus;
    logic isAsm;
    logic statusReadQ; // Last cycle was a status read with cs high

    //####################################################################
    // Address decode
    //####################################################################

    // Low two address bits are byte offsets and carry no meaning
    assign isControl = bus.addr[4:2] == addrControl[4:2];
    assign isStatus  = bus.addr[4:2] == addrStatus[4:2];
    assign isAsm     = bus.addr[4:2] == addrAsmControl[4:2];

    //####################################################################
    // Byte lane writes
    //####################################################################

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            control    <= controlReset;
            asmControl <= '0;
        end else if (bus.cs) begin
            // Control has only the lower half word
            if (isControl) begin
                if (bus.wrEn[0]) begin
                    control[7:0] <= bus.wrData[7:0];
                end
                if (bus.wrEn[1]) begin
                    control[15:8] <= bus.wrData[15:8];
                end
            end
            if (isAsm) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.wrEn[b]) begin
                        asmControl[8*b +: 8] <= bus.wrData[8*b +: 8];
                    end
                end
            end
        end
    end

    //####################################################################
    // Read mux and clear strobe
    //####################################################################

    always_comb begin
        if (!bus.cs) begin
            readData = '0; // Idle bus reads as zero
        end else if (isControl) begin
            readData = {16'h0000, control};
        end else if (isStatus) begin
            readData = {failCnt, frameCnt, errCnt};
        end else if (isAsm) begin
            readData = asmControl;
        end else begin
            readData = '0; // Unmapped word
        end
    end

    // The clear fires one cycle after cs drops on a status read
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            statusReadQ <= 1'b0;
            clearStats  <= 1'b0;
        end else begin
            statusReadQ <= bus.cs && isStatus && (bus.wrEn == 4'b0000);
            clearStats  <= statusReadQ && !bus.cs;
        end
    end

endmodule

`default_nettype wire

// File: logic/rsStatsTop.sv
//####################################################################
// RS decoder statistics top, distributor, lanes, merger, counters, regs
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module rsStatsTop import rsStatsPkg::*; #(
    parameter int maxDepth = 8  // Number of interleave lanes
) (
    input  wire logic      busClk,
    input  wire logic      rstN,
    input  wire cwReport_t report,
    input  wire busReq_t   bus,
    output logic [31:0]    readData,
    output rsControl_t     control,
    output logic [31:0]    asmControl
);

    cwReport_t                         laneWr [maxDepth];    // Distributor to lanes
    laneResult_t                       laneState [maxDepth]; // Lanes to merger
    logic [$clog2(maxDepth + 1)-1:0]   frameDepth;
    logic                              laneDrain;
    frameResult_t                      frame;
    logic                              clearStats;
    logic [7:0]                        failCnt;
    logic [7:0]                        frameCnt;
    logic [15:0]                       errCnt;

    codewordDistributor #(.maxDepth(maxDepth)) u_distributor (
        .busClk, .rstN, .report, .control, .laneWr, .frameDepth
    );

    // One accumulator per interleave lane
    for (genvar i = 0; i < maxDepth; i++) begin : gLane
        laneAccumulator u_lane (
            .busClk, .rstN, .laneWr(laneWr[i]), .laneDrain, .laneState(laneState[i])
        );
    end

    frameMerger #(.maxDepth(maxDepth)) u_merger (
        .busClk, .rstN, .laneState, .laneWr, .frameDepth, .frame, .laneDrain
    );

    rsStatsCounters u_counters (
        .busClk, .rstN, .frame, .clearStats, .failCnt, .frameCnt, .errCnt
    );

    rsRegs u_regs (
        .busClk, .rstN, .bus, .failCnt, .frameCnt, .errCnt,
        .readData, .control, .asmControl, .clearStats
    );

endmodule

`default_nettype wire

// File: tb/tbClkGen.sv
//####################################################################
// Testbench clock and reset source, 10 ns clock and 8 cycle reset
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module tbClkGen #(
    parameter int periodNs    = 10,
    parameter int resetCycles = 8
) (
    output logic busClk,
    output logic rstN
);

    initial begin
        busClk = 1'b0;
        forever #(periodNs / 2.0) busClk = ~busClk;
    end

    // Release on a falling edge so the first rising edge sees a clean reset
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge busClk);
        @(negedge busClk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/rsStatsTb.sv
//####################################################################
// Testbench for the RS statistics block, random reports and bus
// accesses checked against a model of registers, frames and counters
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module rsStatsTb import rsStatsPkg::*; ();

    localparam int regWrites      = 60;  // Random accesses in the register test
    localparam int framesPerPhase = 20;
    localparam int maxGap         = 3;   // Longest idle run between reports
    localparam int depthRounds    = 6;
    localparam int satFrames      = 300;
    localparam int stimCycles     = 200 + regWrites * 8 + depthRounds * 60 + satFrames * 8
        + 8 * (framesPerPhase * 8 * (2 + maxGap) + 40);
    localparam realtime timeoutNs = stimCycles * 10.0 * 2.0;

    logic        busClk;
    logic        rstN;
    cwReport_t   report;
    busReq_t     bus;
    logic [31:0] readData;
    rsControl_t  control;
    logic [31:0] asmControl;
    logic [31:0] lastRead;            // readData seen in the last bus access
    integer      seed = 87957;
    int          checks = 0;
    int          fails = 0;
    int          testFails = 0;
    int          testsClean = 0;
    int          interleaveList [8] = '{1, 2, 3, 4, 5, 8, 0, 15}; // 0 and 15 hit the clamp

    // Model state, registers then frame assembly then counters
    logic [15:0] mCtl = 16'h0010;
    logic [31:0] mAsm = '0;
    int          mPos = 0;
    int          mDepth = 1;
    int          mSum = 0;
    logic        mAnyFail = 1'b0;
    logic [7:0]  mFail = '0;
    logic [7:0]  mFrame = '0;
    logic [15:0] mErr = '0;

    tbClkGen u_clkGen (.busClk, .rstN);

    rsStatsTop #(.maxDepth(8)) u_dut (
        .busClk, .rstN, .report, .bus, .readData, .control, .asmControl
    );

    //####################################################################
    // Model and checks
    //####################################################################

    function automatic int clampDepth(input logic [3:0] interleave);
        if (interleave == 4'd0) return 1;          // Zero still means one codeword
        return (interleave > 4'd8) ? 8 : int'(interleave);
    endfunction

    function automatic logic [31:0] expectedRead(input logic [4:0] addr);
        if (addr[4:2] == addrControl[4:2]) return {16'h0000, mCtl};
        if (addr[4:2] == addrStatus[4:2]) return {mFail, mFrame, mErr};
        if (addr[4:2] == addrAsmControl[4:2]) return mAsm;
        return 32'h0;                              // Unmapped words read zero
    endfunction

    task automatic compareWord(input string sig, input logic [31:0] expV, input logic [31:0] gotV);
        checks++;
        if (gotV !== expV) begin
            fails++;
            testFails++;
            $display("FAIL %s: expected 0x%08h, got 0x%08h at %0t", sig, expV, gotV, $time);
        end
    endtask

    // A frame closes after the depth that was in force at its first codeword
    task automatic modelReport(input logic [7:0] errors, input logic fail);
        if (mPos == 0) begin
            mDepth   = clampDepth(mCtl[7:4]);
            mSum     = 0;
            mAnyFail = 1'b0;
        end
        mSum     = mSum + int'(errors);
        mAnyFail = mAnyFail | fail;
        mPos++;
        if (mPos == mDepth) begin
            mPos = 0;
            if (mFrame != 8'hFF) mFrame++;
            if (mAnyFail && (mFail != 8'hFF)) mFail++;
            mErr = (int'(mErr) + mSum > 65535) ? 16'hFFFF : 16'(int'(mErr) + mSum);
        end
    endtask

    //####################################################################
    // Stimulus, every cycle starts on a falling edge
    //####################################################################

    task automatic driveIdle();
        report = '0;
        bus    = '0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge busClk);
            driveIdle();
            #2 compareWord("readData", 32'h0, readData); // Bus idle reads zero
        end
    endtask

    task automatic sendReport(input logic [7:0] errors, input logic fail);
        @(negedge busClk);
        bus    = '0;
        report = '{valid: 1'b1, errors: errors, fail: fail};
        modelReport(errors, fail);
    endtask

    task automatic sendRandomReport();
        logic [7:0] errors;
        logic [1:0] failDraw;
        errors   = $random(seed);
        failDraw = $random(seed);
        sendReport(errors, failDraw == 2'd0);      // Roughly one codeword in four fails
    endtask

    // One cycle with cs high, then one idle cycle so cs falls before the next access
    task automatic busAccess(input logic [4:0] addr, input logic [3:0] wrEn,
                             input logic [31:0] data);
        @(negedge busClk);
        report = '0;
        bus    = '{cs: 1'b1, addr: addr, wrEn: wrEn, wrData: data};
        #2;
        lastRead = readData;
        compareWord("readData", expectedRead(addr), readData);
        if (addr[4:2] == addrControl[4:2]) begin
            for (int b = 0; b < 2; b++) if (wrEn[b]) mCtl[8*b +: 8] = data[8*b +: 8];
        end else if (addr[4:2] == addrAsmControl[4:2]) begin
            for (int b = 0; b < 4; b++) if (wrEn[b]) mAsm[8*b +: 8] = data[8*b +: 8];
        end else if ((addr[4:2] == addrStatus[4:2]) && (wrEn == 4'b0000)) begin
            mFail  = '0;                           // Status read clears the counters
            mFrame = '0;
            mErr   = '0;
        end
        @(negedge busClk);
        driveIdle();
    endtask

    task automatic writeControl(input logic [3:0] interleave);
        logic [31:0] data;
        data      = $random(seed);
        data[7:4] = interleave;                    // Fill, reserved and rIndex stay random
        busAccess(addrControl, 4'b0011, data);
    endtask

    task automatic readStatus();
        logic [1:0] offset;
        offset = $random(seed);
        busAccess(addrStatus | {3'b000, offset}, 4'b0000, $random(seed));
    endtask

    task automatic endTest(input string name);
        $display("%-28s done, %0d mismatches", name, testFails);
        if (testFails == 0) testsClean++;
        testFails = 0;
    endtask

    //####################################################################
    // Test sequence
    //####################################################################

    initial begin
        logic [4:0] addr;
        logic [3:0] wrEn;
        logic [2:0] word;
        int         d1;
        int         d2;
        int         k;
        driveIdle();
        @(posedge rstN);

        compareWord("control", 32'h0000_0010, {16'h0000, control});
        busAccess(addrControl, 4'b0000, 32'h0);
        busAccess(addrAsmControl, 4'b0000, 32'h0);
        busAccess(addrStatus, 4'b0000, 32'h0);
        endTest("reset values");

        repeat (regWrites) begin
            addr = $random(seed);
            wrEn = $random(seed);
            busAccess(addr, wrEn, $random(seed));
            busAccess(addrControl, 4'b0000, 32'h0);
            busAccess(addrAsmControl, 4'b0000, 32'h0);
            word = 3'(3 + $unsigned($random(seed)) % 5); // Words 3 to 7 are unmapped
            busAccess({word, 2'b01}, 4'b0000, 32'h0);
            compareWord("control", {16'h0000, mCtl}, {16'h0000, control});
            compareWord("asmControl", mAsm, asmControl);
        end
        endTest("byte lane writes");

        foreach (interleaveList[i]) begin
            writeControl(4'(interleaveList[i]));
            repeat (framesPerPhase * clampDepth(4'(interleaveList[i]))) sendRandomReport();
            idleCycles(6);
            readStatus();
            repeat (framesPerPhase * clampDepth(4'(interleaveList[i]))) begin
                sendRandomReport();
                idleCycles($unsigned($random(seed)) % (maxGap + 1));
            end
            idleCycles(6);
            readStatus();
        end
        endTest("frame assembly");

        repeat (depthRounds) begin
            d1 = 2 + $unsigned($random(seed)) % 7;
            d2 = 1 + $unsigned($random(seed)) % 8;
            writeControl(4'(d1));
            k = 1 + $unsigned($random(seed)) % (d1 - 1);
            repeat (k) sendRandomReport();
            writeControl(4'(d2));                  // Lands in the middle of a frame
            repeat (d1 - k) sendRandomReport();
            repeat (2 * d2) sendRandomReport();
            idleCycles(6);
            readStatus();
        end
        endTest("depth change mid-frame");

        writeControl(4'd3);
        repeat (9) sendRandomReport();
        idleCycles(6);
        busAccess(addrControl, 4'b0000, 32'h0);
        busAccess(addrStatus, 4'b1111, $random(seed)); // Write to status is not a read
        busAccess(addrAsmControl, 4'b0001, $random(seed));
        idleCycles(4);
        readStatus();
        compareWord("readData frame count", 32'd3, {24'h0, lastRead[23:16]});
        idleCycles(4);
        readStatus();
        compareWord("readData after clear", 32'h0, lastRead);
        endTest("clear on read");

        writeControl(4'd8);
        repeat (satFrames * 8) sendReport(8'hFF, 1'b1);
        idleCycles(6);
        readStatus();
        compareWord("readData saturated", 32'hFFFF_FFFF, lastRead);
        idleCycles(4);
        endTest("saturation");

        $display("Summary: %0d checks, %0d failed, %0d of 6 tests clean", checks, fails,
                 testsClean);
        if (fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Ends a hung run after twice the expected stimulus time
    initial begin
        #(timeoutNs);
        $display("Timeout: the test sequence did not finish within %0t", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
logic/rsStatsPkg.sv
logic/codewordDistributor.sv
logic/laneAccumulator.sv
logic/frameMerger.sv
logic/rsStatsCounters.sv
logic/rsRegs.sv
logic/rsStatsTop.sv
tb/tbClkGen.sv
tb/rsStatsTb.sv

// File: Bender.yml
package:
  name: rs_stats

sources:
  - files:
      - logic/rsStatsPkg.sv
      - logic/codewordDistributor.sv
      - logic/laneAccumulator.sv
      - logic/frameMerger.sv
      - logic/rsStatsCounters.sv
      - logic/rsRegs.sv
      - logic/rsStatsTop.sv
  - target: test
    files:
      - tb/tbClkGen.sv
      - tb/rsStatsTb.sv
